// ==== common/lau_pkg.sv ====
/*
 * lau_pkg
 * shared definitions for the multi-operand adder: the speed selector,
 * floor-log2 helper, operand and result widths, and vector types
 */

`default_nettype none

package lau_pkg;

	// structure selector for compressor and final adder
	typedef enum logic [1:0] {
		SLOW   = 2'b00,
		MEDIUM = 2'b01,
		FAST   = 2'b10
	} speed_e;

	// floor(log2(n)), meaningful for n > 0
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		// count doublings until p passes n
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

	// number of summed operands, compressor needs at least 4
	localparam int OPERANDS = 6;

	// bits per operand
	localparam int OP_WIDTH = 16;

	// result width, large enough that the full sum never overflows
	localparam int SUM_WIDTH = OP_WIDTH + log2floor(OPERANDS - 1) + 1;

	// one operand
	typedef logic [OP_WIDTH-1:0] operand_t;

	// all operands packed, operand k in slice k
	typedef logic [OPERANDS*OP_WIDTH-1:0] opvec_t;

	// results, carry-save vectors and final sum
	typedef logic [SUM_WIDTH-1:0] sum_t;

endpackage

`default_nettype wire

// ==== csa/cpr.sv ====
/*
 * cpr
 * (m,2)-compressor for one bit column: adds depth input bits plus the
 * intermediate carries of the column below, giving one sum bit, one carry
 * bit and depth-3 intermediate carries for the column above.
 * SLOW uses a linear chain of full adders, otherwise a full-adder tree.
 */

`timescale 1ns/1ps
`default_nettype none

module cpr #(
	parameter int              depth = 4,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [depth-1:0] a,
	input  logic [depth-4:0] ci,
	output logic             s,
	output logic             c,
	output logic [depth-4:0] co
);

	// full-adder sum
	function automatic logic fa_sum(input logic x, input logic y, input logic z);
		return x ^ y ^ z;
	endfunction

	// full-adder carry, majority of three
	function automatic logic fa_maj(input logic x, input logic y, input logic z);
		return (x & y) | (x & z) | (y & z);
	endfunction

	// carries of all depth-2 full adders
	logic [depth-3:0] cot;

	// compressor only defined from four inputs up
	if (depth < 4) begin : g_depth_check
		$error("cpr: depth must be at least 4");
	end

	if (speed == lau_pkg::SLOW) begin : g_linear
		// running sum along the chain
		logic [depth-3:0] sc;

		// first adder takes three input bits
		assign sc[0]  = fa_sum(a[0], a[1], a[2]);
		assign cot[0] = fa_maj(a[0], a[1], a[2]);

		// each further adder: next input bit, one carry in, previous sum
		for (genvar i = 1; i < depth-2; i++) begin : g_fa
			assign sc[i]  = fa_sum(a[i+2], ci[i-1], sc[i-1]);
			assign cot[i] = fa_maj(a[i+2], ci[i-1], sc[i-1]);
		end

		// chain depth is depth-2 adders
		assign s = sc[depth-3];
	end else begin : g_tree
		// signal queue: inputs first, then sums and carries as they appear
		logic [3*depth-6:0] f;

		assign f[depth-1:0] = a;

		for (genvar i = 0; i < depth-2; i++) begin : g_fa
			// pop three from the front, push the sum to the back
			assign f[depth+2*i] = fa_sum(f[3*i], f[3*i+1], f[3*i+2]);
			assign cot[i]       = fa_maj(f[3*i], f[3*i+1], f[3*i+2]);

			// then push one incoming carry behind it
			// last slot would hold a constant zero, so it is left out
			if (i < depth-3) begin : g_cin
				assign f[depth+2*i+1] = ci[i];
			end
		end

		// last sum of the tree
		assign s = f[3*depth-6];
	end

	// first depth-3 carries go to the next column
	assign co = cot[depth-4:0];

	// last carry is the column's carry bit
	assign c = cot[depth-3];

endmodule

`default_nettype wire

// ==== csa/csa_array.sv ====
/*
 * csa_array
 * carry-save reduction of all operands: one compressor per result bit,
 * intermediate carries chained upward column by column.
 * cs_sum + cs_carry equals the sum of all operands.
 */

`timescale 1ns/1ps
`default_nettype none

module csa_array #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  lau_pkg::opvec_t ops,
	output lau_pkg::sum_t   cs_sum,
	output lau_pkg::sum_t   cs_carry
);

	localparam int W  = lau_pkg::SUM_WIDTH;
	localparam int N  = lau_pkg::OPERANDS;
	localparam int OW = lau_pkg::OP_WIDTH;

	// operands split out, slice k is operand k
	lau_pkg::operand_t [N-1:0] opnd;

	// operand bits regrouped by column, zero above OW
	logic [W-1:0][N-1:0] col;

	// intermediate carries out of each column
	logic [W-1:0][N-4:0] ich;

	// carry bit of each column, weight one column up
	logic [W-1:0] col_c;

	assign opnd = ops;

	for (genvar i = 0; i < W; i++) begin : g_col
		// bit i of every operand
		for (genvar k = 0; k < N; k++) begin : g_bit
			if (i < OW) begin : g_op
				assign col[i][k] = opnd[k][i];
			end else begin : g_ext
				assign col[i][k] = 1'b0;
			end
		end

		// column 0 has no carries coming in
		if (i == 0) begin : g_first
			cpr #(
				.depth(N),
				.speed(speed)
			) u_cpr (
				.a (col[i]),
				.ci({(N-3){1'b0}}),
				.s (cs_sum[i]),
				.c (col_c[i]),
				.co(ich[i])
			);
		end else begin : g_next
			cpr #(
				.depth(N),
				.speed(speed)
			) u_cpr (
				.a (col[i]),
				.ci(ich[i-1]),
				.s (cs_sum[i]),
				.c (col_c[i]),
				.co(ich[i])
			);
		end
	end

	// carries shift up one bit
	// top column's carry and ich[W-1] stay zero for in-range inputs, dropped
	assign cs_carry = {col_c[W-2:0], 1'b0};

endmodule

`default_nettype wire

// ==== files.f ====
common/lau_pkg.sv
csa/cpr.sv
csa/csa_array.sv
hdl/cpa_prefix.sv
hdl/add_mop.sv
testbench/tb_add_mop.sv

// ==== hdl/add_mop.sv ====
/*
 * add_mop
 * pipelined adder for six 16-bit operands: input register, carry-save
 * compressor row, register, final carry-propagate adder, output register.
 * results leave three cycles after their inputs, one set per cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module add_mop #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  lau_pkg::opvec_t ops,
	output logic            out_valid,
	output lau_pkg::sum_t   sum
);

	localparam int W = lau_pkg::SUM_WIDTH;

	// stage valid bits, out_valid is the third
	logic v1;
	logic v2;

	// stage 1 data
	lau_pkg::opvec_t ops_q;

	// carry-save vectors, combinational and registered
	lau_pkg::sum_t cs_sum;
	lau_pkg::sum_t cs_carry;
	lau_pkg::sum_t sum_q;
	lau_pkg::sum_t carry_q;

	// final adder output
	lau_pkg::sum_t cpa_s;

	// valid pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1        <= in_valid;
			v2        <= v1;
			out_valid <= v2;
		end
	end

	// data stages load only with their valid, sum holds between results
	always_ff @(posedge clk) begin
		if (in_valid) begin
			ops_q <= ops;
		end
		if (v1) begin
			sum_q   <= cs_sum;
			carry_q <= cs_carry;
		end
		if (v2) begin
			sum <= cpa_s;
		end
	end

	// six operands down to two vectors
	csa_array #(
		.speed(speed)
	) u_csa_array (
		.ops     (ops_q),
		.cs_sum  (cs_sum),
		.cs_carry(cs_carry)
	);

	// two vectors down to one
	cpa_prefix #(
		.speed(speed)
	) u_cpa_prefix (
		.a(sum_q),
		.b(carry_q),
		.s(cpa_s)
	);

	// a set top carry bit would mean the sum lost its top carry
	assert property (@(posedge clk) disable iff (!rst_n)
		v2 |-> !carry_q[W-1])
	else $error("add_mop: carry-save top carry set, sum overflow");

	// valid never unknown once out of reset
	assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid))
	else $error("add_mop: out_valid unknown");

	// fixed three-cycle latency through all stages
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, 3) |-> (out_valid == $past(in_valid, 3)))
	else $error("add_mop: out_valid does not follow in_valid by three cycles");

endmodule

`default_nettype wire

// ==== hdl/cpa_prefix.sv ====
/*
 * cpa_prefix
 * final carry-propagate adder for the carry-save vectors.
 * SLOW ripples the carry, MEDIUM and FAST use a Sklansky prefix tree.
 * carry out of the top bit is not formed, the result never overflows.
 */

`timescale 1ns/1ps
`default_nettype none

module cpa_prefix #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  lau_pkg::sum_t a,
	input  lau_pkg::sum_t b,
	output lau_pkg::sum_t s
);

	localparam int W = lau_pkg::SUM_WIDTH;

	// carries into the top bit only need the lower W-1 bits
	localparam int N = W - 1;

	// prefix levels so that 2**L covers N bits
	localparam int L = lau_pkg::log2floor(N - 1) + 1;

	// bitwise generate over the lower bits
	logic [N-1:0] g;

	// bitwise propagate, full width for the sum
	logic [W-1:0] p;

	// carry into each bit, no carry into bit 0
	logic [W-1:0] c;

	assign g = a[N-1:0] & b[N-1:0];
	assign p = a ^ b;

	if (speed == lau_pkg::SLOW) begin : g_ripple
		assign c[0] = 1'b0;

		// one carry stage per bit
		for (genvar i = 1; i < W; i++) begin : g_bit
			assign c[i] = g[i-1] | (p[i-1] & c[i-1]);
		end
	end else begin : g_sklansky
		// group generate per level, level 0 is the bitwise one
		logic [L:0][N-1:0] gl;

		// group propagate, not needed after the last level
		logic [L-1:0][N-1:0] pl;

		assign gl[0] = g;
		assign pl[0] = p[N-1:0];

		for (genvar l = 1; l <= L; l++) begin : g_lvl
			for (genvar i = 0; i < N; i++) begin : g_bit
				if (((i >> (l-1)) & 1) == 1) begin : g_op
					// top bit of the block below this half
					localparam int J = ((i >> (l-1)) << (l-1)) - 1;

					assign gl[l][i] = gl[l-1][i] | (pl[l-1][i] & gl[l-1][J]);
					if (l < L) begin : g_p
						assign pl[l][i] = pl[l-1][i] & pl[l-1][J];
					end
				end else begin : g_pass
					// lower half of the block passes through
					assign gl[l][i] = gl[l-1][i];
					if (l < L) begin : g_p
						assign pl[l][i] = pl[l-1][i];
					end
				end
			end
		end

		// group generate of bits 0..i is the carry into bit i+1
		assign c = {gl[L], 1'b0};
	end

	// sum bits
	assign s = p ^ c;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the adder testbench with Verilator, once per structure.
set -e
set -o pipefail

cd "$(dirname "$0")"

# name:speed_sel pairs, 0 = SLOW, 2 = FAST
for cfg in slow:0 fast:2; do
	name="${cfg%%:*}"
	sel="${cfg##*:}"
	mdir="obj_${name}"
	log="sim_${name}.log"

	verilator --binary --timing --assert -j 0 \
		-f files.f --top-module tb_add_mop \
		-Gspeed_sel="${sel}" --Mdir "${mdir}" -o sim_tb

	"./${mdir}/sim_tb" | tee "${log}"

	grep -q "Simulation passed" "${log}" || { echo "${name}: no pass line in ${log}"; exit 1; }
done

// ==== testbench/tb_add_mop.sv ====
/*
 * tb_add_mop
 * testbench for the pipelined six-operand adder: random back-to-back and
 * gapped streams, extreme values and walking carry chains, each result
 * checked against an integer-sum model and a three-cycle latency
 */

`timescale 1ns/1ps
`default_nettype none

module tb_add_mop #(
	// 0 selects SLOW, 1 MEDIUM, 2 FAST
	parameter int speed_sel = 2
) ();

	localparam lau_pkg::speed_e SPEED = lau_pkg::speed_e'(speed_sel);
	localparam int N  = lau_pkg::OPERANDS;
	localparam int OW = lau_pkg::OP_WIDTH;

	// stimulus lengths in cycles
	localparam int RST_CYCLES = 8;
	localparam int N_STREAM   = 500;
	localparam int N_GAP      = 400;
	localparam int N_EXT      = 2;
	localparam int N_WALK     = OW;
	localparam int DRAIN      = 6;

	// roughly twice the total stimulus length
	localparam int LIMIT = 2 * (RST_CYCLES + N_STREAM + N_GAP + N_EXT + N_WALK + DRAIN + 8);

	// pipeline depth of the DUT
	localparam int LATENCY = 3;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	lau_pkg::opvec_t ops;
	logic            out_valid;
	lau_pkg::sum_t   sum;

	// operands of the set being driven
	lau_pkg::operand_t opnd [N];

	// pending results with expected sum, drive cycle and test name
	lau_pkg::sum_t exp_q [$];
	int            stamp_q [$];
	string         name_q [$];

	string test_name = "reset";
	int    cycle = 0;

	add_mop #(
		.speed(SPEED)
	) UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.ops      (ops),
		.out_valid(out_valid),
		.sum      (sum)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// prints the reason, then the fail line, then stops
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	// drive one cycle of inputs on the falling edge and record the expected result
	task automatic load_cycle(input bit valid);
		int total;
		total = 0;
		for (int k = 0; k < N; k++) begin
			ops[k*OW +: OW] = opnd[k];
			total = total + int'(opnd[k]);
		end
		in_valid = valid;
		if (valid) begin
			exp_q.push_back(lau_pkg::sum_t'(total));
			stamp_q.push_back(cycle);
			name_q.push_back(test_name);
		end
		@(negedge clk);
	endtask

	// fresh random operand set
	task automatic randomize_ops();
		for (int k = 0; k < N; k++) begin
			opnd[k] = lau_pkg::operand_t'($urandom);
		end
	endtask

	// same value in every operand
	task automatic fill_ops(input lau_pkg::operand_t v);
		for (int k = 0; k < N; k++) begin
			opnd[k] = v;
		end
	endtask

	// cycle count and hang guard
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			stop_on_error($sformatf("timeout: run exceeded %0d cycles", LIMIT));
		end
	end

	// output checks on the falling edge where outputs are stable
	always @(negedge clk) begin
		if (!rst_n) begin
			assert (out_valid == 1'b0)
			else stop_on_error("out_valid high during reset");
		end else if (out_valid) begin
			// a pulse needs a pending input
			assert (exp_q.size() > 0)
			else stop_on_error("out_valid pulse without a pending input");
			if (exp_q.size() > 0) begin
				assert (cycle - stamp_q[0] == LATENCY)
				else stop_on_error($sformatf("MISMATCH %s latency expected %0d actual %0d",
					name_q[0], LATENCY, cycle - stamp_q[0]));
				assert (sum == exp_q[0])
				else stop_on_error($sformatf("MISMATCH %s sum expected %0d actual %0d",
					name_q[0], exp_q[0], sum));
				void'(exp_q.pop_front());
				void'(stamp_q.pop_front());
				void'(name_q.pop_front());
			end
		end else if (stamp_q.size() > 0) begin
			// missing pulse once the oldest input is due
			assert (cycle - stamp_q[0] < LATENCY)
			else stop_on_error($sformatf("no out_valid %0d cycles after input in %s",
				LATENCY, name_q[0]));
		end
	end

	initial begin
		void'($urandom(32'h3b01));
		rst_n    = 1'b0;
		// valid pipeline must stay clear with in_valid high during reset
		in_valid = 1'b1;
		ops      = '0;
		fill_ops('0);

		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// idle after reset keeps out_valid low
		repeat (4) load_cycle(1'b0);

		test_name = "stream";
		for (int i = 0; i < N_STREAM; i++) begin
			randomize_ops();
			load_cycle(1'b1);
		end

		test_name = "gapped";
		for (int i = 0; i < N_GAP; i++) begin
			randomize_ops();
			load_cycle(($urandom & 1) == 1);
		end
		load_cycle(1'b0);

		test_name = "extremes";
		fill_ops('0);
		load_cycle(1'b1);
		// top column and overflow check
		fill_ops('1);
		load_cycle(1'b1);

		test_name = "carry_walk";
		for (int b = 0; b < N_WALK; b++) begin
			fill_ops('0);
			opnd[0] = lau_pkg::operand_t'(1) << b;
			opnd[1] = '1;
			load_cycle(1'b1);
		end

		fill_ops('0);
		repeat (DRAIN) load_cycle(1'b0);

		if (exp_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_on_error($sformatf("%0d results never appeared", exp_q.size()));
		end
	end

endmodule

`default_nettype wire
